//--- common/ifu_pkg.sv
package ifu_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  localparam int set_bits = 3;
  localparam int num_sets = 8;
  localparam int line_words = 2;
  localparam int offset_bits = 3;  // byte in word plus word in line
  localparam int tag_bits = xlen - set_bits - offset_bits;

  typedef enum logic [2:0] {
    kind_alu,     // OP and OP-IMM
    kind_load,
    kind_store,
    kind_branch,
    kind_jal,
    kind_jalr,
    kind_system,
    kind_other    // LUI, AUIPC, fence and anything unknown
  } inst_kind_e;

  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_fence  = 7'b0001111,
    op_op_imm = 7'b0010011,
    op_auipc  = 7'b0010111,
    op_store  = 7'b0100011,
    op_op     = 7'b0110011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    st_idle,
    st_read0,
    st_wait0,
    st_read1,
    st_wait1,
    st_done
  } refill_state_e;

endpackage

//--- common/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if import ifu_pkg::*; ();

  logic            req;         // one-cycle strobe, never while a request is open
  logic [xlen-1:0] req_pc;
  logic            resp_valid;  // exactly one per request
  logic [xlen-1:0] resp_pc;
  logic [xlen-1:0] resp_inst;
  logic            resp_keep;   // low when the response belongs to an overtaken stream

  modport seq (output req, req_pc, resp_keep, input resp_valid);

  modport cache (input req, req_pc, output resp_valid, resp_pc, resp_inst);

  modport pre (input resp_valid, resp_pc, resp_inst, resp_keep);

endinterface

//--- l1i/l1i_cache.sv
`timescale 1ns/1ps

module l1i_cache import ifu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            invalidate,
  output logic [xlen-1:0] mem_araddr,
  output logic            mem_arvalid,
  input  logic            mem_rvalid,
  input  logic [xlen-1:0] mem_rdata,
  fetch_if.cache          fetch
);

  logic [tag_bits-1:0] tag_mem [num_sets];
  logic [xlen-1:0]     data_mem [num_sets][line_words];
  logic [num_sets-1:0] line_valid;

  logic [xlen-1:0] line_buf [line_words];  // collects the two refill words

  refill_state_e   state;
  logic [xlen-1:0] pc_q;
  logic            hit_q;
  logic [xlen-1:0] hit_word_q;
  logic            killed;  // an invalidate was seen during this refill

  logic [tag_bits-1:0]    req_tag;
  logic [set_bits-1:0]    req_idx;
  logic [offset_bits-3:0] req_off;
  logic                   lookup_hit;

  logic [set_bits-1:0]    fill_idx;
  logic [offset_bits-3:0] fill_off;
  logic [xlen-1:0]        line_base;

  assign req_tag = fetch.req_pc[xlen-1 -: tag_bits];
  assign req_idx = fetch.req_pc[offset_bits +: set_bits];
  assign req_off = fetch.req_pc[offset_bits-1:2];

  // an invalidate in the request cycle already counts, so the line is refetched
  assign lookup_hit = line_valid[req_idx] && (tag_mem[req_idx] == req_tag) && !invalidate;

  assign fill_idx  = pc_q[offset_bits +: set_bits];
  assign fill_off  = pc_q[offset_bits-1:2];
  assign line_base = {pc_q[xlen-1:offset_bits], {offset_bits{1'b0}}};

  assign mem_arvalid = (state == st_read0) || (state == st_read1);
  assign mem_araddr  = (state == st_read1) ? line_base + 32'd4 : line_base;

  assign fetch.resp_valid = hit_q || (state == st_done);
  assign fetch.resp_pc    = pc_q;
  assign fetch.resp_inst  = (state == st_done) ? line_buf[fill_off] : hit_word_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      hit_q      <= 1'b0;
      killed     <= 1'b0;
      line_valid <= '0;
    end else begin
      hit_q <= 1'b0;
      case (state)
        st_idle: begin
          if (fetch.req) begin
            if (lookup_hit) begin
              hit_q <= 1'b1;  // answer in the next cycle
            end else begin
              state  <= st_read0;
              killed <= invalidate;
            end
          end
        end
        st_read0: begin
          state <= st_wait0;
        end
        st_wait0: begin
          if (mem_rvalid) begin
            state <= st_read1;
          end
        end
        st_read1: begin
          state <= st_wait1;
        end
        st_wait1: begin
          if (mem_rvalid) begin
            state <= st_done;
          end
        end
        st_done: begin
          line_valid[fill_idx] <= !killed;
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase

      // placed last so it overrides the line fill in st_done
      if (invalidate) begin
        line_valid <= '0;
        killed     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch.req) begin
      pc_q       <= fetch.req_pc;
      hit_word_q <= data_mem[req_idx][req_off];
    end
    if (mem_rvalid && (state == st_wait0)) begin
      line_buf[0] <= mem_rdata;
    end
    if (mem_rvalid && (state == st_wait1)) begin
      line_buf[1] <= mem_rdata;
    end
    if (state == st_done) begin
      tag_mem[fill_idx] <= pc_q[xlen-1 -: tag_bits];
      for (int w = 0; w < line_words; w++) begin
        data_mem[fill_idx][w] <= line_buf[w];
      end
    end
  end

endmodule

//--- logic/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer import ifu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_pc,
  input  logic            jump,
  input  logic [xlen-1:0] jump_target,
  fetch_if.seq            fetch
);

  logic [xlen-1:0] pc;
  logic            req_q;
  logic            outstanding;
  logic            stale;  // the open request was overtaken by a redirect
  logic            issue;

  // every response is followed at once by the next request
  assign issue = fetch.resp_valid || !outstanding;

  assign fetch.req    = req_q;
  assign fetch.req_pc = pc;

  // a redirect in the response cycle squashes that response as well
  assign fetch.resp_keep = !stale && !redirect;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc          <= reset_pc;
      req_q       <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
    end else begin
      req_q <= issue;
      if (issue) begin
        outstanding <= 1'b1;
      end

      if (redirect) begin
        pc <= redirect_pc;  // wins over a jump in the same cycle
      end else if (fetch.resp_valid && !stale) begin
        pc <= jump ? jump_target : pc + 32'd4;
      end

      if (fetch.resp_valid) begin
        stale <= 1'b0;
      end else if (redirect && outstanding) begin
        stale <= 1'b1;
      end
    end
  end

endmodule

//--- logic/predecode.sv
`timescale 1ns/1ps

module predecode import ifu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  fetch_if.pre            fetch,
  output logic            jump,
  output logic [xlen-1:0] jump_target,
  output logic            inst_valid,
  output logic [xlen-1:0] inst_pc,
  output logic [xlen-1:0] inst_word,
  output inst_kind_e      inst_kind
);

  opcode_e         opcode;
  inst_kind_e      kind;
  logic [xlen-1:0] j_imm;
  logic            keep;

  assign opcode = opcode_e'(fetch.resp_inst[6:0]);

  assign j_imm = {{12{fetch.resp_inst[31]}}, fetch.resp_inst[19:12],
                  fetch.resp_inst[20], fetch.resp_inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      op_op, op_op_imm:         kind = kind_alu;
      op_load:                  kind = kind_load;
      op_store:                 kind = kind_store;
      op_branch:                kind = kind_branch;
      op_jal:                   kind = kind_jal;
      op_jalr:                  kind = kind_jalr;
      op_system:                kind = kind_system;
      op_lui, op_auipc, op_fence: kind = kind_other;
      default:                  kind = kind_other;
    endcase
  end

  assign keep        = fetch.resp_valid && fetch.resp_keep;
  assign jump        = keep && (kind == kind_jal);  // only JAL redirects fetch here
  assign jump_target = fetch.resp_pc + j_imm;

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= keep;
    end
  end

  always_ff @(posedge clock) begin
    if (keep) begin
      inst_pc   <= fetch.resp_pc;
      inst_word <= fetch.resp_inst;
      inst_kind <= kind;
    end
  end

endmodule

//--- logic/ifu_top.sv
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_pc,
  input  logic            invalidate,
  output logic [xlen-1:0] mem_araddr,
  output logic            mem_arvalid,
  input  logic            mem_rvalid,
  input  logic [xlen-1:0] mem_rdata,
  output logic            inst_valid,
  output logic [xlen-1:0] inst_pc,
  output logic [xlen-1:0] inst_word,
  output inst_kind_e      inst_kind
);

  logic            jump;
  logic [xlen-1:0] jump_target;

  fetch_if fetch ();

  fetch_sequencer u_seq (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .jump        (jump),
    .jump_target (jump_target),
    .fetch       (fetch.seq)
  );

  l1i_cache u_cache (
    .clock       (clock),
    .reset       (reset),
    .invalidate  (invalidate),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .fetch       (fetch.cache)
  );

  predecode u_pre (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch.pre),
    .jump        (jump),
    .jump_target (jump_target),
    .inst_valid  (inst_valid),
    .inst_pc     (inst_pc),
    .inst_word   (inst_word),
    .inst_kind   (inst_kind)
  );

endmodule

//--- test/ifu_assertions.sv
`timescale 1ns/1ps

module ifu_assertions (
  input logic clock,
  input logic reset,
  input logic req,
  input logic resp_valid,
  input logic mem_arvalid,
  input logic mem_rvalid,
  input logic inst_valid
);

  logic read_open;  // a memory read was issued and has not returned yet

  always_ff @(posedge clock) begin
    if (reset) begin
      read_open <= 1'b0;
    end else if (mem_arvalid) begin
      read_open <= 1'b1;
    end else if (mem_rvalid) begin
      read_open <= 1'b0;
    end
  end

  single_read: assert property (@(posedge clock) disable iff (reset)
    mem_arvalid |-> !read_open)
    else $error("mem_arvalid raised while a read was outstanding");

  inst_gap: assert property (@(posedge clock) disable iff (reset)
    inst_valid |=> !inst_valid)
    else $error("inst_valid high in two consecutive cycles");

  // registers hold reset values from the second reset cycle on
  quiet_reset: assert property (@(posedge clock)
    reset && $past(reset) |-> !req && !resp_valid && !mem_arvalid && !inst_valid)
    else $error("strobe high while reset is asserted");

endmodule

//--- test/ifu_tb.sv
`timescale 1ns/1ps

module ifu_tb import ifu_pkg::*; ();

  localparam int num_checks = 2000;
  localparam int revisits = 8;
  localparam int watchdog_cycles = 400 * (num_checks + 2 * revisits);

  logic            clock;
  logic            reset;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;
  logic            invalidate;
  logic [xlen-1:0] mem_araddr;
  logic            mem_arvalid;
  logic            mem_rvalid;
  logic [xlen-1:0] mem_rdata;
  logic            inst_valid;
  logic [xlen-1:0] inst_pc;
  logic [xlen-1:0] inst_word;
  inst_kind_e      inst_kind;

  logic [31:0] rng_state = 32'haaab_ccb8;
  logic [31:0] exp_pc = reset_pc;  // next pc the reference model expects
  int          gen = 0;  // memory generation, bumped with every invalidate
  int          checked = 0;
  int          read_count = 0;
  logic        read_pending = 1'b0;
  int          read_delay = 0;
  logic [31:0] read_addr;
  logic        saw_inst = 1'b0;

  ifu_top uut (.*);

  bind ifu_top ifu_assertions u_assert (
    .clock       (clock),
    .reset       (reset),
    .req         (fetch.req),
    .resp_valid  (fetch.resp_valid),
    .mem_arvalid (mem_arvalid),
    .mem_rvalid  (mem_rvalid),
    .inst_valid  (inst_valid)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [6:0] pick_opcode(input int sel);
    case (sel)
      0: return 7'b0000011;
      1: return 7'b0001111;
      2: return 7'b0010011;
      3: return 7'b0010111;
      4: return 7'b0100011;
      5: return 7'b0110011;
      6: return 7'b0110111;
      7: return 7'b1100011;
      8: return 7'b1100111;
      9: return 7'b1110011;
      default: return 7'b1111111;  // not an RV32 major opcode
    endcase
  endfunction

  // generation 0 holds no JAL so the first stretch of fetch is purely sequential
  function automatic logic [31:0] mem_word(input logic [31:0] addr, input int g);
    logic [31:0] h;
    logic [20:0] imm;
    int          k;
    h = xorshift(xorshift(addr ^ (32'(g) * 32'h9e37_79b9) ^ 32'h6c8e_9cf5));
    if (g != 0 && h[2:0] == 3'd0) begin
      k = int'(h[8:4]) - 16;
      if (k == 0) begin
        k = 3;
      end
      imm = 21'(k * 4);
      return {imm[20], imm[10:1], imm[11], imm[19:12], h[15:11], 7'b1101111};
    end
    return {h[31:7], pick_opcode(int'(h[7:3]) % 11)};
  endfunction

  function automatic logic [31:0] jal_offset(input logic [31:0] w);
    logic [20:0] imm;
    imm[20]    = w[31];
    imm[19:12] = w[19:12];
    imm[11]    = w[20];
    imm[10:1]  = w[30:21];
    imm[0]     = 1'b0;
    return {{11{imm[20]}}, imm};
  endfunction

  function automatic inst_kind_e kind_of(input logic [31:0] w);
    case (w[6:0])
      7'b0110011, 7'b0010011: return kind_alu;
      7'b0000011:             return kind_load;
      7'b0100011:             return kind_store;
      7'b1100011:             return kind_branch;
      7'b1101111:             return kind_jal;
      7'b1100111:             return kind_jalr;
      7'b1110011:             return kind_system;
      default:                return kind_other;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_output();
    logic [31:0] w;
    saw_inst = inst_valid;
    if (inst_valid) begin
      w = mem_word(exp_pc, gen);
      compare("inst_pc", inst_pc, exp_pc);
      compare("inst_word", inst_word, w);
      compare("inst_kind", {29'd0, inst_kind}, {29'd0, kind_of(w)});
      if (w[6:0] == 7'b1101111) begin
        exp_pc = exp_pc + jal_offset(w);
      end else begin
        exp_pc = exp_pc + 32'd4;
      end
      checked++;
    end
  endtask

  task automatic serve_memory();
    mem_rvalid = 1'b0;
    if (read_pending) begin
      read_delay--;
      if (read_delay == 0) begin
        mem_rvalid   = 1'b1;
        mem_rdata    = mem_word(read_addr, gen);
        read_pending = 1'b0;
      end
    end
    if (mem_arvalid) begin
      read_pending = 1'b1;
      read_addr    = mem_araddr;
      read_delay   = int'(next_rand() & 32'h3) + 1;  // 1 to 4 cycles
      read_count++;
    end
  endtask

  task automatic step_cycle(input logic do_redirect, input logic [31:0] target,
                            input logic do_invalidate);
    @(negedge clock);
    redirect   = 1'b0;
    invalidate = 1'b0;
    check_output();
    serve_memory();
    if (do_redirect) begin
      redirect    = 1'b1;
      redirect_pc = target;
      exp_pc      = target;
      if (do_invalidate) begin
        invalidate = 1'b1;
        gen++;
      end
    end
  endtask

  task automatic wait_inst();
    step_cycle(1'b0, 32'h0, 1'b0);
    while (!saw_inst) begin
      step_cycle(1'b0, 32'h0, 1'b0);
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout: fewer than %0d instructions arrived within %0d cycles",
             num_checks, watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] base;
    int          reads_before;
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    invalidate  = 1'b0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    repeat (16) @(negedge clock);
    reset = 1'b0;

    while (checked < num_checks) begin
      r = next_rand();
      if (checked >= 200 && (r % 40) == 0) begin
        step_cycle(1'b1, reset_pc + (next_rand() & 32'h0000_00fc), 1'b1);
      end else if (checked >= 200 && r[15:8] < 8'd4) begin
        step_cycle(1'b1, reset_pc + (next_rand() & 32'h0000_00fc), 1'b0);
      end else begin
        step_cycle(1'b0, 32'h0, 1'b0);
      end
    end

    // the second visit of a line must be served without any memory read
    for (int i = 0; i < revisits; i++) begin
      base = reset_pc + (next_rand() & 32'h0000_00f8);
      while (mem_word(base, gen) ==? 32'b????????????????????????_?1101111) begin
        base = reset_pc + (next_rand() & 32'h0000_00f8);
      end
      step_cycle(1'b1, base, 1'b0);
      wait_inst();
      reads_before = read_count;
      step_cycle(1'b1, base, 1'b0);
      wait_inst();
      compare("mem_arvalid count", read_count, reads_before);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- verilog.f
common/ifu_pkg.sv
common/fetch_if.sv
l1i/l1i_cache.sv
logic/fetch_sequencer.sv
logic/predecode.sv
logic/ifu_top.sv
test/ifu_assertions.sv
test/ifu_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ifu_tb -o ifu_sim -f verilog.f \
  || { echo "build failed"; exit 1; }
./obj_dir/ifu_sim 2>&1 | tee sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
